//--- cdc_bridge.f
design/fifo_cfg_pkg.sv
design/chan_pkg.sv
design/gray_sync.sv
design/gray_ptr_counter.sv
design/fifo_ram_asym.sv
design/async_fifo_asym.sv
design/chan_arbiter.sv
design/cdc_bridge_top.sv
verif/tb_checker.sv
verif/tb_cdc_bridge.sv

//--- design/async_fifo_asym.sv
module async_fifo_asym (
   input  logic                 w_clk_i,
   input  logic                 r_clk_i,
   input  logic                 reset_i,
   // write side, one byte per edge
   input  logic                 w_en_i,
   input  fifo_cfg_pkg::byte_t  w_data_i,
   output logic                 w_full_o,
   output fifo_cfg_pkg::level_t w_level_o,
   // read side, one word per pop
   input  logic                 r_en_i,
   output fifo_cfg_pkg::word_t  r_data_o,
   output logic                 r_empty_o,
   output fifo_cfg_pkg::level_t r_level_o
);

   import fifo_cfg_pkg::*;
   import chan_pkg::*;

   // pointers in their own domain
   wptr_t w_wptr_gray;
   wptr_t w_wptr_bin;
   rptr_t r_rptr_gray;
   rptr_t r_rptr_bin;

   // pointers after crossing
   wptr_t r_wptr_gray;
   wptr_t r_wptr_bin;
   rptr_t w_rptr_gray;
   rptr_t w_rptr_bin;

   fifo_st_e w_st_q;
   fifo_st_e w_st_d;
   fifo_st_e r_st_q;
   fifo_st_e r_st_d;

   logic w_en_int;
   logic r_en_int;

   // prefix xor from the msb down
   // read pointers go through zero-extended, leading zeros stay zero
   function automatic wptr_t gray2bin(input wptr_t g);
      wptr_t b;
      b[WADDR_W-1] = g[WADDR_W-1];
      for (int i = WADDR_W - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   assign w_en_int = w_en_i & ~w_full_o;
   assign r_en_int = r_en_i & ~r_empty_o;

   gray_ptr_counter #(.W(WADDR_W)) wptr_counter_inst (
      .clk_i   (w_clk_i),
      .reset_i (reset_i),
      .en_i    (w_en_int),
      .gray_o  (w_wptr_gray),
      .bin_o   (w_wptr_bin)
   );

   gray_ptr_counter #(.W(RADDR_W)) rptr_counter_inst (
      .clk_i   (r_clk_i),
      .reset_i (reset_i),
      .en_i    (r_en_int),
      .gray_o  (r_rptr_gray),
      .bin_o   (r_rptr_bin)
   );

   // write pointer into the read domain
   gray_sync #(.W(WADDR_W)) wptr_sync_inst (
      .clk_i   (r_clk_i),
      .reset_i (reset_i),
      .gray_i  (w_wptr_gray),
      .gray_o  (r_wptr_gray)
   );

   // read pointer into the write domain
   gray_sync #(.W(RADDR_W)) rptr_sync_inst (
      .clk_i   (w_clk_i),
      .reset_i (reset_i),
      .gray_i  (r_rptr_gray),
      .gray_o  (w_rptr_gray)
   );

   assign r_wptr_bin = gray2bin(r_wptr_gray);
   assign w_rptr_bin = rptr_t'(gray2bin(wptr_t'(w_rptr_gray)));

   // levels in bytes, read pointer scaled up by the word size
   // wrap bit keeps 32 apart from 0
   assign w_level_o = w_wptr_bin - {w_rptr_bin, {RATIO_LOG{1'b0}}};
   assign r_level_o = r_wptr_bin - {r_rptr_bin, {RATIO_LOG{1'b0}}};

   // flags come from state only
   assign w_full_o  = (w_st_q == ST_INIT) || (w_st_q == ST_FULL);
   assign r_empty_o = (r_st_q == ST_INIT) || (r_st_q == ST_EMPTY);

   // write side flag FSM
   always_comb begin
      w_st_d = w_st_q;
      case (w_st_q)
         ST_INIT: begin
            w_st_d = ST_NORMAL;
         end
         ST_FULL: begin
            // leave once a pop has crossed over
            if (w_level_o < level_t'(FIFO_BYTES)) begin
               w_st_d = ST_NORMAL;
            end
         end
         default: begin
            if (w_en_int && (w_level_o >= level_t'(FIFO_BYTES - 1))) begin
               w_st_d = ST_FULL;
            end
         end
      endcase
   end

   // read side flag FSM
   always_comb begin
      r_st_d = r_st_q;
      case (r_st_q)
         ST_INIT: begin
            r_st_d = ST_EMPTY;
         end
         ST_EMPTY: begin
            // need a whole word before popping
            if (r_level_o >= level_t'(WORD_W / BYTE_W)) begin
               r_st_d = ST_NORMAL;
            end
         end
         default: begin
            if (r_en_int && (r_level_o < level_t'(2 * WORD_W / BYTE_W))) begin
               r_st_d = ST_EMPTY;
            end
         end
      endcase
   end

   always_ff @(posedge w_clk_i) begin
      if (reset_i) begin
         w_st_q <= ST_INIT;
      end else begin
         w_st_q <= w_st_d;
      end
   end

   always_ff @(posedge r_clk_i) begin
      if (reset_i) begin
         r_st_q <= ST_INIT;
      end else begin
         r_st_q <= r_st_d;
      end
   end

   fifo_ram_asym fifo_ram_asym_inst (
      .w_clk_i  (w_clk_i),
      .w_en_i   (w_en_int),
      .w_addr_i (w_wptr_bin[ADDR_W-1:0]),
      .w_data_i (w_data_i),
      .r_clk_i  (r_clk_i),
      .r_en_i   (r_en_int),
      .r_addr_i (r_rptr_bin[ADDR_W-RATIO_LOG-1:0]),
      .r_data_o (r_data_o)
   );

   // the writer upstream must already respect full
   a_no_write_full: assert property (@(posedge w_clk_i) disable iff (reset_i)
      w_en_i |-> !w_full_o);

   // a pop always finds a complete word behind the synced write pointer
   a_pop_has_word: assert property (@(posedge r_clk_i) disable iff (reset_i)
      r_en_int |-> (r_level_o >= level_t'(WORD_W / BYTE_W)));

   a_w_level_max: assert property (@(posedge w_clk_i) disable iff (reset_i)
      w_level_o <= level_t'(FIFO_BYTES));

   a_r_level_max: assert property (@(posedge r_clk_i) disable iff (reset_i)
      r_level_o <= level_t'(FIFO_BYTES));

endmodule

//--- design/cdc_bridge_top.sv
module cdc_bridge_top (
   input  logic                                       w_clk_i,
   input  logic                                       r_clk_i,
   input  logic                                       reset_i,
   // write domain channels
   input  chan_pkg::chan_req_t [chan_pkg::N_CHAN-1:0] chan_i,
   output logic [chan_pkg::N_CHAN-1:0]                chan_gnt_o,
   output logic                                       w_full_o,
   output fifo_cfg_pkg::level_t                       w_level_o,
   // read domain consumer
   input  logic                                       r_en_i,
   output fifo_cfg_pkg::word_t                        r_data_o,
   output logic                                       r_empty_o,
   output fifo_cfg_pkg::level_t                       r_level_o
);

   import fifo_cfg_pkg::*;

   // arbiter to FIFO write port
   logic  arb_w_en;
   byte_t arb_w_data;

   chan_arbiter chan_arbiter_inst (
      .w_clk_i     (w_clk_i),
      .reset_i     (reset_i),
      .chan_i      (chan_i),
      .fifo_full_i (w_full_o),
      .chan_gnt_o  (chan_gnt_o),
      .w_en_o      (arb_w_en),
      .w_data_o    (arb_w_data)
   );

   async_fifo_asym async_fifo_asym_inst (
      .w_clk_i   (w_clk_i),
      .r_clk_i   (r_clk_i),
      .reset_i   (reset_i),
      .w_en_i    (arb_w_en),
      .w_data_i  (arb_w_data),
      .w_full_o  (w_full_o),
      .w_level_o (w_level_o),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_empty_o (r_empty_o),
      .r_level_o (r_level_o)
   );

endmodule

//--- design/chan_arbiter.sv
module chan_arbiter (
   input  logic                                       w_clk_i,
   input  logic                                       reset_i,
   input  chan_pkg::chan_req_t [chan_pkg::N_CHAN-1:0] chan_i,
   input  logic                                       fifo_full_i,
   output logic [chan_pkg::N_CHAN-1:0]                chan_gnt_o,
   output logic                                       w_en_o,
   output fifo_cfg_pkg::byte_t                        w_data_o
);

   import chan_pkg::*;

   typedef logic [$clog2(N_CHAN)-1:0] chan_idx_t;

   logic [N_CHAN-1:0] req_vec;
   chan_idx_t         last_q;
   chan_idx_t         gnt_idx;
   logic              gnt_any;

   always_comb begin
      for (int k = 0; k < N_CHAN; k++) begin
         req_vec[k] = chan_i[k].req;
      end
   end

   // first requester after the last winner, wrapping around
   always_comb begin
      gnt_any = 1'b0;
      gnt_idx = last_q;
      for (int k = 1; k <= N_CHAN; k++) begin
         if (!gnt_any && req_vec[(int'(last_q) + k) % N_CHAN]) begin
            gnt_any = 1'b1;
            gnt_idx = chan_idx_t'((int'(last_q) + k) % N_CHAN);
         end
      end
   end

   // nothing goes out while the FIFO is full, requests just wait
   assign w_en_o     = gnt_any && !fifo_full_i;
   assign chan_gnt_o = w_en_o ? (N_CHAN'(1) << gnt_idx) : '0;
   assign w_data_o   = chan_i[gnt_idx].data;

   // start so that channel 0 wins the first tie
   always_ff @(posedge w_clk_i) begin
      if (reset_i) begin
         last_q <= chan_idx_t'(N_CHAN - 1);
      end else if (w_en_o) begin
         last_q <= gnt_idx;
      end
   end

   a_gnt_onehot: assert property (@(posedge w_clk_i) disable iff (reset_i)
      $onehot0(chan_gnt_o));

   a_gnt_to_req: assert property (@(posedge w_clk_i) disable iff (reset_i)
      (chan_gnt_o & ~req_vec) == '0);

   a_no_gnt_full: assert property (@(posedge w_clk_i) disable iff (reset_i)
      fifo_full_i |-> (chan_gnt_o == '0));

endmodule

//--- design/chan_pkg.sv
package chan_pkg;

   import fifo_cfg_pkg::*;

   // number of peer byte channels
   localparam int N_CHAN = 2;

   // one channel's pending byte
   // req stays high with data stable until granted
   typedef struct packed {
      logic  req;
      byte_t data;
   } chan_req_t;

   // flag state of one FIFO side
   // write side walks INIT, NORMAL and FULL
   // read side walks INIT, EMPTY and NORMAL
   typedef enum logic [1:0] {
      ST_INIT,
      ST_EMPTY,
      ST_NORMAL,
      ST_FULL
   } fifo_st_e;

endpackage

//--- design/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

   // data widths on each side of the FIFO
   localparam int BYTE_W = 8;
   localparam int WORD_W = 32;

   // byte address space of the storage
   localparam int ADDR_W = 5;

   // log2 of bytes per word
   localparam int RATIO_LOG = 2;

   // pointers carry one extra wrap bit
   localparam int WADDR_W = ADDR_W + 1;
   localparam int RADDR_W = WADDR_W - RATIO_LOG;

   localparam int FIFO_BYTES = 1 << ADDR_W;

   typedef logic [BYTE_W-1:0] byte_t;
   typedef logic [WORD_W-1:0] word_t;

   // fill level counted in bytes, 0 up to FIFO_BYTES
   typedef logic [ADDR_W:0] level_t;

   // write pointer counts bytes, read pointer counts words
   typedef logic [WADDR_W-1:0] wptr_t;
   typedef logic [RADDR_W-1:0] rptr_t;

endpackage

//--- design/fifo_ram_asym.sv
module fifo_ram_asym (
   // byte write port
   input  logic                                                w_clk_i,
   input  logic                                                w_en_i,
   input  logic [fifo_cfg_pkg::ADDR_W-1:0]                     w_addr_i,
   input  fifo_cfg_pkg::byte_t                                 w_data_i,
   // word read port
   input  logic                                                r_clk_i,
   input  logic                                                r_en_i,
   input  logic [fifo_cfg_pkg::ADDR_W-fifo_cfg_pkg::RATIO_LOG-1:0] r_addr_i,
   output fifo_cfg_pkg::word_t                                 r_data_o
);

   import fifo_cfg_pkg::*;

   // byte-addressed storage
   byte_t mem [FIFO_BYTES];

   always_ff @(posedge w_clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // word read, lowest byte address lands in the low bits
   // output holds between reads
   always_ff @(posedge r_clk_i) begin
      if (r_en_i) begin
         for (int k = 0; k < (1 << RATIO_LOG); k++) begin
            r_data_o[k*BYTE_W +: BYTE_W] <= mem[{r_addr_i, RATIO_LOG'(k)}];
         end
      end
   end

endmodule

//--- design/gray_ptr_counter.sv
module gray_ptr_counter #(
   parameter int W = 4
) (
   input  logic         clk_i,
   input  logic         reset_i,
   input  logic         en_i,
   output logic [W-1:0] gray_o,
   output logic [W-1:0] bin_o
);

   // next binary count
   logic [W-1:0] bin_next;

   assign bin_next = bin_o + W'(en_i);

   // gray value comes straight from a flop, never from logic,
   // so the other domain never samples a decoding glitch
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         bin_o  <= '0;
         gray_o <= '0;
      end else begin
         bin_o  <= bin_next;
         gray_o <= bin_next ^ (bin_next >> 1);
      end
   end

endmodule

//--- design/gray_sync.sv
module gray_sync #(
   parameter int W = 4
) (
   input  logic         clk_i,
   input  logic         reset_i,
   input  logic [W-1:0] gray_i,
   output logic [W-1:0] gray_o
);

   // first stage may go metastable
   logic [W-1:0] meta_q;

   // only one bit of gray_i changes per source edge,
   // so the sampled value is either the old or the new pointer
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         meta_q <= '0;
         gray_o <= '0;
      end else begin
         meta_q <= gray_i;
         gray_o <= meta_q;
      end
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the cdc_bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f cdc_bridge.f --top-module tb_cdc_bridge \
   -Mdir obj_dir -o sim_cdc_bridge
if [ $? -ne 0 ]; then
   echo "run_sim: Verilator build failed"
   exit 1
fi

./obj_dir/sim_cdc_bridge > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "run_sim: simulation exited with status $status"
   exit 1
fi

if grep -q "Something failed" "$LOG"; then
   echo "run_sim: FAIL"
   exit 1
fi

echo "run_sim: PASS"
exit 0

//--- verif/tb_cdc_bridge.sv
module tb_cdc_bridge;

   timeunit 1ns;
   timeprecision 1ps;

   import fifo_cfg_pkg::*;
   import chan_pkg::*;

   localparam int unsigned SEED = 32'hee5f_6c03;
   localparam int TOTAL_BYTES = 3000;
   // r_clk cycles of slow popping at the start
   localparam int FILL_CYCLES = 400;
   // roughly six times the expected run of about 3500 w_clk cycles
   localparam int MAX_CYCLES = 20000;

   logic                   w_clk;
   logic                   r_clk;
   logic                   reset;
   chan_req_t [N_CHAN-1:0] chan = '0;
   logic [N_CHAN-1:0]      chan_gnt;
   logic                   w_full;
   level_t                 w_level;
   logic                   r_en = 1'b0;
   word_t                  r_data;
   logic                   r_empty;
   level_t                 r_level;

   int   issued = 0;
   int   r_cycles = 0;
   int   cycles;
   logic timed_out;
   logic report_req;
   logic report_done;
   int   err_count;
   int   bytes_written;
   int   model_count;

   cdc_bridge_top cdc_bridge_top_inst (
      .w_clk_i    (w_clk),
      .r_clk_i    (r_clk),
      .reset_i    (reset),
      .chan_i     (chan),
      .chan_gnt_o (chan_gnt),
      .w_full_o   (w_full),
      .w_level_o  (w_level),
      .r_en_i     (r_en),
      .r_data_o   (r_data),
      .r_empty_o  (r_empty),
      .r_level_o  (r_level)
   );

   tb_checker tb_checker_inst (
      .w_clk_i         (w_clk),
      .r_clk_i         (r_clk),
      .reset_i         (reset),
      .chan_i          (chan),
      .chan_gnt_i      (chan_gnt),
      .w_full_i        (w_full),
      .w_level_i       (w_level),
      .r_en_i          (r_en),
      .r_data_i        (r_data),
      .r_empty_i       (r_empty),
      .r_level_i       (r_level),
      .report_i        (report_req),
      .report_done_o   (report_done),
      .err_count_o     (err_count),
      .bytes_written_o (bytes_written),
      .model_count_o   (model_count)
   );

   // rising edges at 50 + 100k and 65 + 130k never coincide
   initial begin
      w_clk = 1'b0;
      forever #50 w_clk = ~w_clk;
   end

   initial begin
      r_clk = 1'b0;
      forever #65 r_clk = ~r_clk;
   end

   // slow consumer first so the FIFO fills up
   function automatic int read_pct(input int cycle);
      if (cycle < FILL_CYCLES) begin
         return 10;
      end
      return 75;
   endfunction

   // a waiting channel holds req and data until its grant
   always @(posedge w_clk) begin
      if (reset) begin
         chan <= '0;
      end else begin
         for (int c = 0; c < N_CHAN; c++) begin
            if (!chan[c].req || chan_gnt[c]) begin
               if (issued < TOTAL_BYTES && int'($urandom_range(0, 99)) < 60) begin
                  chan[c].req  <= 1'b1;
                  chan[c].data <= byte_t'($urandom);
                  issued++;
               end else begin
                  chan[c].req <= 1'b0;
               end
            end
         end
      end
   end

   always @(posedge r_clk) begin
      if (reset) begin
         r_en     <= 1'b0;
         r_cycles <= 0;
      end else begin
         r_cycles <= r_cycles + 1;
         r_en     <= int'($urandom_range(0, 99)) < read_pct(r_cycles);
      end
   end

   initial begin
      void'($urandom(SEED));
      reset = 1'b1;
      report_req = 1'b0;
      repeat (2) @(posedge r_clk);
      reset <= 1'b0;
      cycles = 0;
      while (!(bytes_written == TOTAL_BYTES && model_count == 0) && cycles < MAX_CYCLES) begin
         @(negedge w_clk);
         cycles++;
      end
      timed_out = !(bytes_written == TOTAL_BYTES && model_count == 0);
      if (timed_out) begin
         $display("timeout: stream did not drain after %0d w_clk cycles", cycles);
      end else begin
         // last popped word is checked one r_clk later
         repeat (3) @(posedge r_clk);
      end
      report_req = 1'b1;
      wait (report_done);
      if (!timed_out && err_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

//--- verif/tb_checker.sv
module tb_checker (
   input  logic                                       w_clk_i,
   input  logic                                       r_clk_i,
   input  logic                                       reset_i,
   input  chan_pkg::chan_req_t [chan_pkg::N_CHAN-1:0] chan_i,
   input  logic [chan_pkg::N_CHAN-1:0]                chan_gnt_i,
   input  logic                                       w_full_i,
   input  fifo_cfg_pkg::level_t                       w_level_i,
   input  logic                                       r_en_i,
   input  fifo_cfg_pkg::word_t                        r_data_i,
   input  logic                                       r_empty_i,
   input  fifo_cfg_pkg::level_t                       r_level_i,
   input  logic                                       report_i,
   output logic                                       report_done_o,
   output int                                         err_count_o,
   output int                                         bytes_written_o,
   output int                                         model_count_o
);

   timeunit 1ns;
   timeprecision 1ps;

   import fifo_cfg_pkg::*;
   import chan_pkg::*;

   localparam int WORD_BYTES = WORD_W / BYTE_W;

   // every accepted byte in write order, read side walks rd_idx
   byte_t stream [$];
   int    pushed = 0;
   int    rd_idx = 0;
   int    last_gnt = -1;
   int    w_edges = 0;
   int    r_edges = 0;
   word_t exp_word;
   logic  exp_valid = 1'b0;

   int arb_err = 0;
   int full_err = 0;
   int wlvl_err = 0;
   int data_err = 0;
   int empty_err = 0;
   int rlvl_err = 0;

   assign err_count_o     = arb_err + full_err + wlvl_err + data_err + empty_err + rlvl_err;
   assign bytes_written_o = pushed;
   assign model_count_o   = pushed - rd_idx;

   always @(posedge w_clk_i) begin
      logic [N_CHAN-1:0] req;
      logic [N_CHAN-1:0] exp_gnt;
      logic              found;
      int                count;
      int                idx;
      if (reset_i) begin
         w_edges = 0;
      end else begin
         w_edges++;
         count = pushed - rd_idx;
         exp_gnt = '0;
         found = 1'b0;
         for (int c = 0; c < N_CHAN; c++) begin
            req[c] = chan_i[c].req;
         end
         // first requester after the last winner
         for (int k = 1; k <= N_CHAN; k++) begin
            idx = (last_gnt + k) % N_CHAN;
            if (!found && !w_full_i && req[idx]) begin
               exp_gnt[idx] = 1'b1;
               found = 1'b1;
            end
         end
         // no history yet, any single requester may win
         if (last_gnt < 0 && found && $onehot(chan_gnt_i) && (chan_gnt_i & ~req) == '0) begin
            exp_gnt = chan_gnt_i;
         end
         if (chan_gnt_i !== exp_gnt) begin
            arb_err++;
            $display("FAILED at %0t: grant expected %b got %b (req %b, full %b)",
                     $time, exp_gnt, chan_gnt_i, req, w_full_i);
         end
         // init cycle reads as full, then space opens up
         if ((w_edges == 1 && !w_full_i) || (w_edges == 2 && w_full_i) ||
             (count >= FIFO_BYTES && !w_full_i)) begin
            full_err++;
            $display("FAILED at %0t: w_full_o expected %0b got %0b with %0d bytes held",
                     $time, !w_full_i, w_full_i, count);
         end
         // pops reach this side late, so the level may only overstate
         if (w_level_i < count || w_level_i > FIFO_BYTES) begin
            wlvl_err++;
            $display("FAILED at %0t: w_level_o expected %0d to %0d got %0d",
                     $time, count, FIFO_BYTES, w_level_i);
         end
         for (int c = 0; c < N_CHAN; c++) begin
            if (chan_gnt_i[c]) begin
               stream.push_back(chan_i[c].data);
               pushed++;
               last_gnt = c;
            end
         end
      end
   end

   always @(posedge r_clk_i) begin
      word_t word;
      int    count;
      if (reset_i) begin
         r_edges = 0;
      end else begin
         r_edges++;
         count = pushed - rd_idx;
         // holds the last popped word, also across ignored pops
         if (exp_valid && r_data_i !== exp_word) begin
            data_err++;
            $display("FAILED at %0t: r_data_o expected %h got %h", $time, exp_word, r_data_i);
         end
         if ((r_edges == 1 || count < WORD_BYTES) && !r_empty_i) begin
            empty_err++;
            $display("FAILED at %0t: r_empty_o expected 1 got 0 with %0d bytes held",
                     $time, count);
         end
         if (r_level_i > count || r_level_i > FIFO_BYTES) begin
            rlvl_err++;
            $display("FAILED at %0t: r_level_o expected at most %0d got %0d",
                     $time, count, r_level_i);
         end
         if (r_en_i && !r_empty_i) begin
            if (count < WORD_BYTES) begin
               data_err++;
               $display("error at %0t: pop accepted with only %0d bytes written", $time, count);
            end else begin
               // first byte lands in the low bits
               for (int k = 0; k < WORD_BYTES; k++) begin
                  word[k*BYTE_W +: BYTE_W] = stream[rd_idx + k];
               end
               rd_idx += WORD_BYTES;
               exp_word = word;
               exp_valid = 1'b1;
            end
         end
      end
   end

   initial begin
      report_done_o = 1'b0;
      wait (report_i);
      $display("errors: arbitration %0d, full %0d, write level %0d, data %0d, empty %0d, %s %0d",
               arb_err, full_err, wlvl_err, data_err, empty_err, "read level", rlvl_err);
      report_done_o = 1'b1;
   end

endmodule
